/* rtl/cachePkg.sv */
package cachePkg;

  // data and block geometry
  localparam int WordWidth  = 32;
  localparam int BlockWords = 4;
  localparam int BlockWidth = WordWidth * BlockWords;

  // main memory and cache sizes
  localparam int MemBlocks  = 256;
  localparam int CacheLines = 16;

  // config field widths
  localparam int WaitWidth  = 4;
  localparam int CountWidth = 16;

  // address split: tag | index | word offset
  localparam int OffsetWidth    = $clog2(BlockWords);
  localparam int IndexWidth     = $clog2(CacheLines);
  localparam int BlockAddrWidth = $clog2(MemBlocks);
  localparam int TagWidth       = BlockAddrWidth - IndexWidth;
  localparam int AddrWidth      = BlockAddrWidth + OffsetWidth;

  typedef logic [WordWidth-1:0]      wordT;
  // word 0 sits in the low bits
  typedef logic [BlockWidth-1:0]     blockT;
  typedef logic [AddrWidth-1:0]      addrT;
  typedef logic [BlockAddrWidth-1:0] blockAddrT;
  typedef logic [WaitWidth-1:0]      waitT;
  typedef logic [CountWidth-1:0]     countT;
  typedef logic [TagWidth-1:0]       tagT;
  typedef logic [IndexWidth-1:0]     indexT;
  typedef logic [OffsetWidth-1:0]    offsetT;

  // config register select
  typedef enum logic [1:0] {
    cfgWait   = 2'd0,
    cfgEnable = 2'd1,
    cfgHits   = 2'd2,
    cfgMisses = 2'd3
  } cfgSelT;

  // processor side request
  typedef struct packed {
    logic write;
    addrT addr;
    wordT wdata;
  } cpuReqT;

  // block request to main memory
  typedef struct packed {
    logic      write;
    blockAddrT blockAddr;
    blockT     wblock;
  } memReqT;

  // config access, writes to a counter clear it
  typedef struct packed {
    cfgSelT sel;
    wordT   wdata;
  } cfgReqT;

  typedef enum logic [1:0] {memIdle, memRequested, memRetrieved} memStateT;

  typedef enum logic [1:0] {ctrlIdle, ctrlFetch, ctrlWrite, ctrlRespond} ctrlStateT;

endpackage

/* rtl/blockMemory.sv */
module blockMemory (
  input  logic              clk,
  input  logic              arstN,
  input  logic              memReqValid,
  input  cachePkg::memReqT  memReq,
  input  cachePkg::waitT    waitCycles,
  output logic              memValid,
  output cachePkg::blockT   rblock
);

  import cachePkg::*;

  memStateT  state;
  waitT      waitQ;
  waitT      count;
  blockAddrT addrQ;
  logic      reqTaken;

  // block storage, contents undefined until written
  blockT memArr [MemBlocks];

  // a strobe is only taken while idle
  assign reqTaken = memReqValid && (state == memIdle);

  // wait sequencing
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state <= memIdle;
      count <= '0;
      waitQ <= '0;
    end
    else
    begin
      case (state)
        memIdle:
        begin
          count <= '0;
          if (reqTaken)
          begin
            // wait count sampled once per request
            waitQ <= waitCycles;
            count <= waitT'(1);
            // zero wait goes straight to the data cycle
            if (waitCycles == '0)
            begin
              state <= memRetrieved;
            end
            else
            begin
              state <= memRequested;
            end
          end
        end
        memRequested:
        begin
          if (count == waitQ)
          begin
            state <= memRetrieved;
            count <= '0;
          end
          else
          begin
            count <= count + waitT'(1);
          end
        end
        memRetrieved:
        begin
          // single valid cycle then back to idle
          state <= memIdle;
          count <= '0;
        end
        default:
        begin
          state <= memIdle;
          count <= '0;
        end
      endcase
    end
  end

  // block address latched with the request
  always_ff @(posedge clk)
  begin
    if (reqTaken)
    begin
      addrQ <= memReq.blockAddr;
    end
  end

  // whole block written when the strobe is taken
  always_ff @(posedge clk)
  begin
    if (reqTaken && memReq.write)
    begin
      memArr[memReq.blockAddr] <= memReq.wblock;
    end
  end

  assign memValid = (state == memRetrieved);

  // read after write gives the new contents
  assign rblock = memArr[addrQ];

endmodule

/* rtl/cacheController.sv */
module cacheController (
  input  logic              clk,
  input  logic              arstN,
  input  logic              cpuReqValid,
  input  cachePkg::cpuReqT  cpuReq,
  input  logic              cacheEnable,
  output logic              respValid,
  output cachePkg::wordT    rdata,
  output logic              busy,
  output logic              memReqValid,
  output cachePkg::memReqT  memReq,
  input  logic              memValid,
  input  cachePkg::blockT   rblock,
  output logic              hitPulse,
  output logic              missPulse
);

  import cachePkg::*;

  // pick one word out of a block
  function automatic wordT getWord(blockT blk, offsetT off);
    return blk[off * WordWidth +: WordWidth];
  endfunction

  // replace one word of a block
  function automatic blockT putWord(blockT blk, offsetT off, wordT w);
    blockT res;
    res = blk;
    res[off * WordWidth +: WordWidth] = w;
    return res;
  endfunction

  ctrlStateT state;

  // line store
  blockT                 dataArr [CacheLines];
  tagT                   tagArr  [CacheLines];
  logic [CacheLines-1:0] validArr;

  // request held for the miss and write paths
  cpuReqT reqQ;
  logic   enableQ;
  logic   lineMatchQ;

  offsetT reqOff;
  indexT  reqIdx;
  tagT    reqTag;
  offsetT qOff;
  indexT  qIdx;
  tagT    qTag;
  logic   accept;
  logic   lineMatch;
  logic   lineHit;
  logic   fetchDone;
  logic   fillLine;
  blockT  mergedHit;
  blockT  mergedFetch;
  blockT  fillBlock;

  // incoming address split
  assign reqOff = cpuReq.addr[OffsetWidth-1:0];
  assign reqIdx = cpuReq.addr[OffsetWidth +: IndexWidth];
  assign reqTag = cpuReq.addr[AddrWidth-1 -: TagWidth];

  // held address split
  assign qOff = reqQ.addr[OffsetWidth-1:0];
  assign qIdx = reqQ.addr[OffsetWidth +: IndexWidth];
  assign qTag = reqQ.addr[AddrWidth-1 -: TagWidth];

  // tag compare in the request cycle
  assign accept    = cpuReqValid && (state == ctrlIdle);
  assign lineMatch = validArr[reqIdx] && (tagArr[reqIdx] == reqTag);
  // a disabled cache never hits
  assign lineHit   = cacheEnable && lineMatch;
  assign hitPulse  = accept && lineHit;
  assign missPulse = accept && !lineHit;

  assign mergedHit   = putWord(dataArr[reqIdx], reqOff, cpuReq.wdata);
  assign mergedFetch = putWord(rblock, qOff, reqQ.wdata);
  assign fetchDone   = (state == ctrlFetch) && memValid;
  assign fillBlock   = reqQ.write ? mergedFetch : rblock;
  // allocate only when enabled
  // a disabled write still refreshes a line already holding the block
  assign fillLine    = fetchDone && (enableQ || (reqQ.write && lineMatchQ));

  assign busy = (state != ctrlIdle);

  // control state, strobes and valid bits
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state       <= ctrlIdle;
      respValid   <= 1'b0;
      memReqValid <= 1'b0;
      validArr    <= '0;
    end
    else
    begin
      respValid   <= 1'b0;
      memReqValid <= 1'b0;
      case (state)
        ctrlIdle:
        begin
          if (accept)
          begin
            if (lineHit && !cpuReq.write)
            begin
              // read hit answers next cycle, stays idle
              respValid <= 1'b1;
            end
            else
            begin
              // write hit goes through, everything else fetches
              memReqValid <= 1'b1;
              state       <= lineHit ? ctrlWrite : ctrlFetch;
            end
          end
        end
        ctrlFetch:
        begin
          if (memValid)
          begin
            if (reqQ.write)
            begin
              // merged block goes back out
              memReqValid <= 1'b1;
              state       <= ctrlWrite;
            end
            else
            begin
              respValid <= 1'b1;
              state     <= ctrlRespond;
            end
          end
          if (fillLine)
          begin
            validArr[qIdx] <= 1'b1;
          end
        end
        ctrlWrite:
        begin
          if (memValid)
          begin
            respValid <= 1'b1;
            state     <= ctrlRespond;
          end
        end
        ctrlRespond:
        begin
          // busy drops after the response cycle
          state <= ctrlIdle;
        end
        default:
        begin
          state <= ctrlIdle;
        end
      endcase
    end
  end

  // payload: held request, line data, tags, memory request, read data
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      reqQ       <= cpuReq;
      enableQ    <= cacheEnable;
      lineMatchQ <= lineMatch;
      // writes echo the stored word
      rdata      <= cpuReq.write ? cpuReq.wdata : getWord(dataArr[reqIdx], reqOff);
      if (lineHit && cpuReq.write)
      begin
        dataArr[reqIdx] <= mergedHit;
        memReq          <= '{write: 1'b1, blockAddr: cpuReq.addr[AddrWidth-1:OffsetWidth],
                             wblock: mergedHit};
      end
      else if (!lineHit)
      begin
        memReq <= '{write: 1'b0, blockAddr: cpuReq.addr[AddrWidth-1:OffsetWidth],
                    wblock: '0};
      end
    end
    if (fetchDone)
    begin
      if (fillLine)
      begin
        dataArr[qIdx] <= fillBlock;
        tagArr[qIdx]  <= qTag;
      end
      if (reqQ.write)
      begin
        memReq <= '{write: 1'b1, blockAddr: reqQ.addr[AddrWidth-1:OffsetWidth],
                    wblock: mergedFetch};
      end
      else
      begin
        rdata <= getWord(rblock, qOff);
      end
    end
  end

endmodule

/* rtl/cacheConfig.sv */
module cacheConfig (
  input  logic              clk,
  input  logic              arstN,
  input  logic              cfgWe,
  input  cachePkg::cfgReqT  cfgReq,
  output cachePkg::wordT    cfgRdata,
  input  logic              hitPulse,
  input  logic              missPulse,
  output cachePkg::waitT    waitCycles,
  output logic              cacheEnable
);

  import cachePkg::*;

  countT hitCount;
  countT missCount;

  // wait count and enable
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      waitCycles  <= waitT'(2);
      cacheEnable <= 1'b1;
    end
    else if (cfgWe)
    begin
      if (cfgReq.sel == cfgWait)
      begin
        waitCycles <= cfgReq.wdata[WaitWidth-1:0];
      end
      if (cfgReq.sel == cfgEnable)
      begin
        cacheEnable <= cfgReq.wdata[0];
      end
    end
  end

  // event counters, saturating
  // a write to a counter clears it and wins over a pulse
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      hitCount  <= '0;
      missCount <= '0;
    end
    else
    begin
      if (cfgWe && (cfgReq.sel == cfgHits))
      begin
        hitCount <= '0;
      end
      else if (hitPulse && (hitCount != '1))
      begin
        hitCount <= hitCount + countT'(1);
      end
      if (cfgWe && (cfgReq.sel == cfgMisses))
      begin
        missCount <= '0;
      end
      else if (missPulse && (missCount != '1))
      begin
        missCount <= missCount + countT'(1);
      end
    end
  end

  // read port, zero-extended to a word
  always_comb
  begin
    case (cfgReq.sel)
      cfgWait:   cfgRdata = wordT'(waitCycles);
      cfgEnable: cfgRdata = wordT'(cacheEnable);
      cfgHits:   cfgRdata = wordT'(hitCount);
      cfgMisses: cfgRdata = wordT'(missCount);
      default:   cfgRdata = '0;
    endcase
  end

endmodule

/* rtl/cacheTop.sv */
module cacheTop (
  input  logic              clk,
  input  logic              arstN,
  input  logic              cpuReqValid,
  input  cachePkg::cpuReqT  cpuReq,
  output logic              respValid,
  output cachePkg::wordT    rdata,
  output logic              busy,
  input  logic              cfgWe,
  input  cachePkg::cfgReqT  cfgReq,
  output cachePkg::wordT    cfgRdata
);

  import cachePkg::*;

  // controller to memory
  logic   memReqValid;
  memReqT memReq;
  logic   memValid;
  blockT  rblock;

  // config links
  waitT waitCycles;
  logic cacheEnable;
  logic hitPulse;
  logic missPulse;

  // registers and counters
  cacheConfig u_config (
    .clk        (clk),
    .arstN      (arstN),
    .cfgWe      (cfgWe),
    .cfgReq     (cfgReq),
    .cfgRdata   (cfgRdata),
    .hitPulse   (hitPulse),
    .missPulse  (missPulse),
    .waitCycles (waitCycles),
    .cacheEnable(cacheEnable)
  );

  // line store and miss handling
  cacheController u_ctrl (
    .clk        (clk),
    .arstN      (arstN),
    .cpuReqValid(cpuReqValid),
    .cpuReq     (cpuReq),
    .cacheEnable(cacheEnable),
    .respValid  (respValid),
    .rdata      (rdata),
    .busy       (busy),
    .memReqValid(memReqValid),
    .memReq     (memReq),
    .memValid   (memValid),
    .rblock     (rblock),
    .hitPulse   (hitPulse),
    .missPulse  (missPulse)
  );

  // slow backing store
  blockMemory u_mem (
    .clk        (clk),
    .arstN      (arstN),
    .memReqValid(memReqValid),
    .memReq     (memReq),
    .waitCycles (waitCycles),
    .memValid   (memValid),
    .rblock     (rblock)
  );

endmodule

/* testbench/cacheTop_properties.sv */
module cacheTop_properties (
  input logic              clk,
  input logic              arstN,
  input logic              cpuReqValid,
  input cachePkg::cpuReqT  cpuReq,
  input logic              respValid,
  input logic              busy,
  input logic              memReqValid,
  input logic              memValid,
  input logic              hitPulse,
  input logic              missPulse,
  input cachePkg::waitT    waitCycles
);

  import cachePkg::*;

  // failures seen so far, read by the testbench
  int   failCount = 0;
  logic reqTaken;
  logic respPending;
  int   respLeft;
  logic memPending;
  int   memLeft;

  assign reqTaken = cpuReqValid && !busy;

  // cycles left until the response is due
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      respPending <= 1'b0;
      respLeft    <= 0;
    end
    else if (reqTaken)
    begin
      respPending <= 1'b1;
      if (hitPulse && !cpuReq.write)
      begin
        respLeft <= 1;
      end
      else if (missPulse && cpuReq.write)
      begin
        // fetch, merge, then block write
        respLeft <= 2 * int'(waitCycles) + 5;
      end
      else
      begin
        respLeft <= int'(waitCycles) + 3;
      end
    end
    else if (respPending)
    begin
      respLeft <= respLeft - 1;
      if (respLeft == 1)
      begin
        respPending <= 1'b0;
      end
    end
  end

  // cycles left until the memory answers
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      memPending <= 1'b0;
      memLeft    <= 0;
    end
    else if (memReqValid)
    begin
      memPending <= 1'b1;
      memLeft    <= int'(waitCycles) + 1;
    end
    else if (memPending)
    begin
      memLeft <= memLeft - 1;
      if (memLeft == 1)
      begin
        memPending <= 1'b0;
      end
    end
  end

  // one response, exactly when due
  respTiming: assert property (@(posedge clk) disable iff (!arstN)
    respValid == (respPending && respLeft == 1))
  else
  begin
    failCount++;
    $error("respValid out of step with the request timing");
  end

  memTiming: assert property (@(posedge clk) disable iff (!arstN)
    memValid == (memPending && memLeft == 1))
  else
  begin
    failCount++;
    $error("memValid not W+1 cycles after memReqValid");
  end

  noReqWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
    !(cpuReqValid && busy))
  else
  begin
    failCount++;
    $error("request made while busy");
  end

  // one pulse for every taken request, never both
  pulsesExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(hitPulse && missPulse) && ((hitPulse || missPulse) == reqTaken))
  else
  begin
    failCount++;
    $error("hit and miss pulses not exactly one per request");
  end

  // anything but a read hit makes the controller busy
  busyRises: assert property (@(posedge clk) disable iff (!arstN)
    (reqTaken && !(hitPulse && !cpuReq.write)) |=> busy)
  else
  begin
    failCount++;
    $error("busy did not rise after a request");
  end

  busyFalls: assert property (@(posedge clk) disable iff (!arstN)
    (respValid && busy) |=> !busy)
  else
  begin
    failCount++;
    $error("busy still high after the response");
  end

endmodule

bind cacheTop cacheTop_properties u_props (
  .clk        (clk),
  .arstN      (arstN),
  .cpuReqValid(cpuReqValid),
  .cpuReq     (cpuReq),
  .respValid  (respValid),
  .busy       (busy),
  .memReqValid(memReqValid),
  .memValid   (memValid),
  .hitPulse   (hitPulse),
  .missPulse  (missPulse),
  .waitCycles (waitCycles)
);

/* testbench/cacheTb.sv */
module cacheTb;

  import cachePkg::*;

  localparam int RandomCount   = 40;
  localparam int WaitCount     = 16;
  localparam int DisabledCount = 20;
  // directed accesses plus every random phase
  localparam int NumRequests   = 9 + RandomCount + 2 * WaitCount + 2 * DisabledCount;
  localparam int CycleLimit    = 20 * NumRequests + 200;

  logic   clk;
  logic   arstN;
  logic   cpuReqValid;
  cpuReqT cpuReq;
  logic   respValid;
  wordT   rdata;
  logic   busy;
  logic   cfgWe;
  cfgReqT cfgReq;
  wordT   cfgRdata;

  // reference model: flat word memory plus tag shadow
  wordT                  memModel     [MemBlocks * BlockWords];
  bit                    writtenModel [MemBlocks * BlockWords];
  tagT                   shadowTag    [CacheLines];
  logic [CacheLines-1:0] shadowValid;
  int                    waitModel;
  logic                  enableModel;
  int                    hitModel;
  int                    missModel;
  logic [31:0]           lcgState = 32'h37f1_0a9b;
  int                    cycleCount = 0;

  cacheTop u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .cpuReqValid(cpuReqValid),
    .cpuReq     (cpuReq),
    .respValid  (respValid),
    .rdata      (rdata),
    .busy       (busy),
    .cfgWe      (cfgWe),
    .cfgReq     (cfgReq),
    .cfgRdata   (cfgRdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic abortRun();
    $display("tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  // watchdog and bound property failures
  always @(negedge clk)
  begin
    cycleCount++;
    if (u_dut.u_props.failCount != 0)
    begin
      $display("a bound property failed, see the assertion error above");
      abortRun();
    end
    else if (cycleCount > CycleLimit)
    begin
      $display("timeout after %0d cycles without finishing", cycleCount);
      abortRun();
    end
  end

  task automatic cfgWrite(input cfgSelT sel, input wordT data);
    cfgWe  = 1'b1;
    cfgReq = '{sel: sel, wdata: data};
    @(negedge clk);
    cfgWe = 1'b0;
  endtask

  // read port is combinational, sampled a half cycle later
  task automatic cfgCheck(input string name, input cfgSelT sel, input wordT expected);
    cfgReq = '{sel: sel, wdata: '0};
    @(negedge clk);
    checkValue(name, expected, cfgRdata);
  endtask

  // predict, drive one request, wait for the response and check it
  task automatic cpuAccess(input string name, input logic write, input addrT addr,
                           input wordT data);
    indexT idx;
    tagT   tag;
    logic  hit;
    int    expLat;
    int    lat;
    wordT  expData;
    idx = addr[5:2];
    tag = addr[9:6];
    hit = enableModel && shadowValid[idx] && (shadowTag[idx] == tag);
    if (hit)
      hitModel++;
    else
      missModel++;
    if (hit && !write)
      expLat = 1;
    else if (!hit && write)
      expLat = 2 * waitModel + 5;
    else
      expLat = waitModel + 3;
    if (write)
    begin
      memModel[addr]     = data;
      writtenModel[addr] = 1'b1;
    end
    expData = memModel[addr];
    // allocate on any enabled miss
    if (!hit && enableModel)
    begin
      shadowValid[idx] = 1'b1;
      shadowTag[idx]   = tag;
    end
    cpuReqValid = 1'b1;
    cpuReq      = '{write: write, addr: addr, wdata: data};
    @(negedge clk);
    cpuReqValid = 1'b0;
    // this sample already lies in the cycle after the request
    lat         = 1;
    while (!respValid)
    begin
      @(negedge clk);
      lat++;
    end
    checkValue({name, " latency"}, 32'(expLat), 32'(lat));
    checkValue({name, " rdata"}, expData, rdata);
    while (busy)
      @(negedge clk);
  endtask

  // small tag and index range so lines conflict and hit often
  task automatic randomAccesses(input string name, input int count);
    logic [31:0] r;
    addrT        addr;
    logic        write;
    for (int i = 0; i < count; i++)
    begin
      r     = lcgNext();
      addr  = {2'b00, r[27:26], 2'b00, r[25:24], r[23:22]};
      // never read a word that was not written
      write = r[31] || !writtenModel[addr];
      cpuAccess(name, write, addr, lcgNext());
    end
  endtask

  task automatic countersCheck(input string name);
    cfgCheck({name, " hits"}, cfgHits, wordT'(hitModel));
    cfgCheck({name, " misses"}, cfgMisses, wordT'(missModel));
  endtask

  initial
  begin
    arstN       = 1'b0;
    cpuReqValid = 1'b0;
    cpuReq      = '0;
    cfgWe       = 1'b0;
    cfgReq      = '0;
    waitModel   = 2;
    enableModel = 1'b1;
    hitModel    = 0;
    missModel   = 0;
    shadowValid = '0;
    repeat (5) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    cfgCheck("reset wait", cfgWait, 32'd2);
    cfgCheck("reset enable", cfgEnable, 32'd1);
    countersCheck("reset");
    // write miss, write hit, read hit
    cpuAccess("write miss", 1'b1, 10'h045, 32'hcafe_0001);
    cpuAccess("write hit", 1'b1, 10'h045, 32'hcafe_0002);
    cpuAccess("read hit", 1'b0, 10'h045, '0);
    // same index, other tag
    cpuAccess("evict write", 1'b1, 10'h145, 32'hbeef_0003);
    cpuAccess("read miss", 1'b0, 10'h045, '0);
    cpuAccess("evict read", 1'b0, 10'h145, '0);
    cpuAccess("read hit after fill", 1'b0, 10'h145, '0);
    randomAccesses("random", RandomCount);
    countersCheck("after random");
    // counter writes clear
    cfgWrite(cfgHits, 32'hffff_ffff);
    cfgCheck("hits cleared", cfgHits, '0);
    cfgWrite(cfgMisses, 32'h1234);
    cfgCheck("misses cleared", cfgMisses, '0);
    hitModel  = 0;
    missModel = 0;
    // longer memory wait
    cfgWrite(cfgWait, 32'd5);
    waitModel = 5;
    cfgCheck("wait 5", cfgWait, 32'd5);
    randomAccesses("wait 5", WaitCount);
    // zero wait
    cfgWrite(cfgWait, 32'd0);
    waitModel = 0;
    cfgCheck("wait 0", cfgWait, 32'd0);
    randomAccesses("wait 0", WaitCount);
    cfgWrite(cfgWait, 32'd2);
    waitModel = 2;
    // disabled cache
    cfgWrite(cfgEnable, 32'd0);
    enableModel = 1'b0;
    cfgCheck("disable", cfgEnable, 32'd0);
    randomAccesses("disabled", DisabledCount);
    cpuAccess("disabled write", 1'b1, 10'h045, 32'hd00d_0004);
    cpuAccess("disabled read", 1'b0, 10'h045, '0);
    countersCheck("disabled");
    cfgWrite(cfgEnable, 32'd1);
    enableModel = 1'b1;
    randomAccesses("re-enabled", DisabledCount);
    countersCheck("final");
    @(negedge clk);
    if (u_dut.u_props.failCount == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      $display("tests failed");
      $fatal(1, "bound property failures: %0d", u_dut.u_props.failCount);
    end
  end

endmodule

/* vlog.f */
rtl/cachePkg.sv
rtl/blockMemory.sv
rtl/cacheController.sv
rtl/cacheConfig.sv
rtl/cacheTop.sv
testbench/cacheTop_properties.sv
testbench/cacheTb.sv

/* Bender.yml */
package:
  name: cache

sources:
  # design
  - rtl/cachePkg.sv
  - rtl/blockMemory.sv
  - rtl/cacheController.sv
  - rtl/cacheConfig.sv
  - rtl/cacheTop.sv

  # testbench
  - target: test
    files:
      - testbench/cacheTop_properties.sv
      - testbench/cacheTb.sv
